// ==== src/mlr_pkg.sv ====
package mlr_pkg;

    localparam int DATA_W       = 12;   // pixel width
    localparam int PIX_PER_BEAT = 4;
    localparam int BUS_W        = 64;   // memory data width
    localparam int DIM_W        = 13;   // width / height counters
    localparam int REG_A_W      = 12;
    localparam int ADR_W        = 32;
    localparam int OFS_W        = 16;   // line offset
    localparam int FIDX_W       = 16;

    // pixel packing in memory, code 3 falls back to RAW8
    typedef enum logic [1:0] {
        RAW8  = 2'd0,
        RAW10 = 2'd1,
        RAW12 = 2'd2
    } pack_fmt_e;

    typedef enum logic [REG_A_W-1:0] {
        CTRL      = 12'h000,  // bit0 start, bit1 sof enable
        FMT       = 12'h004,
        START_ADR = 12'h008,
        LINE_OFS  = 12'h00C,
        WIDTH     = 12'h010,  // in beats
        HEIGHT    = 12'h014,
        FIDX      = 12'h018,
        STATUS    = 12'h01C,  // bit0 done (w1c), bit1 busy
        IRQ_EN    = 12'h020
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } fetch_state_e;

endpackage

// ==== src/mlr_cfg_if.sv ====
interface mlr_cfg_if;

    logic                       start;      // one-cycle pulse
    mlr_pkg::pack_fmt_e         pack_fmt;
    logic [mlr_pkg::ADR_W-1:0]  start_adr;
    logic [mlr_pkg::OFS_W-1:0]  line_ofs;
    logic [mlr_pkg::DIM_W-1:0]  width;
    logic [mlr_pkg::DIM_W-1:0]  height;

    modport source (
        output start, pack_fmt, start_adr, line_ofs, width, height
    );

    modport sink (
        input start, pack_fmt, start_adr, line_ofs, width, height
    );

    // unpacker side, format plus frame start for its flags
    modport fmt_rd (
        input start, pack_fmt
    );

endinterface

// ==== src/mlr_word_if.sv ====
interface mlr_word_if;

    logic                       valid;
    logic [mlr_pkg::BUS_W-1:0]  data;
    logic                       last_pix;   // last beat of a line
    logic                       last_line;  // beat belongs to the last line
    logic                       pop;        // credit back to fetch

    modport source (
        output valid, data, last_pix, last_line,
        input  pop
    );

    modport sink (
        input  valid, data, last_pix, last_line,
        output pop
    );

endinterface

// ==== src/mlr_reg_bank.sv ====
module mlr_reg_bank (
    input  logic                         clk_kernel,
    input  logic                         rst,
    input  logic                         ioa_cs,
    input  logic                         ioa_wr,
    input  logic                         ioa_rd,
    input  logic [mlr_pkg::REG_A_W-1:0]  ioa_a,
    input  logic [31:0]                  ioa_wdata,
    output logic                         ioa_rdy,
    output logic [31:0]                  ioa_rdata,
    input  logic                         frame_done,
    mlr_cfg_if.source                    cfg,
    output logic                         sof_en,
    output logic [mlr_pkg::FIDX_W-1:0]   fidx,
    output logic                         interrupt
);

    logic                 busy;
    logic                 done;
    logic                 irq_en;
    logic                 acc;
    logic                 wr_en;
    logic [31:0]          rd_val;
    mlr_pkg::reg_addr_e   reg_sel;

    assign acc     = ioa_cs & (ioa_wr | ioa_rd);
    assign wr_en   = ioa_cs & ioa_wr;
    assign reg_sel = mlr_pkg::reg_addr_e'(ioa_a);

    assign interrupt = done & irq_en;

    always_comb begin
        rd_val = '0;
        case (reg_sel)
            mlr_pkg::CTRL:      rd_val = {30'b0, sof_en, 1'b0};  // start reads 0
            mlr_pkg::FMT:       rd_val = 32'(cfg.pack_fmt);
            mlr_pkg::START_ADR: rd_val = 32'(cfg.start_adr);
            mlr_pkg::LINE_OFS:  rd_val = 32'(cfg.line_ofs);
            mlr_pkg::WIDTH:     rd_val = 32'(cfg.width);
            mlr_pkg::HEIGHT:    rd_val = 32'(cfg.height);
            mlr_pkg::FIDX:      rd_val = 32'(fidx);
            mlr_pkg::STATUS:    rd_val = {30'b0, busy, done};
            mlr_pkg::IRQ_EN:    rd_val = {31'b0, irq_en};
            default:            rd_val = '0;
        endcase
    end

    always_ff @(posedge clk_kernel) begin
        if (rst) begin
            ioa_rdy       <= 1'b0;
            ioa_rdata     <= '0;
            cfg.start     <= 1'b0;
            cfg.pack_fmt  <= mlr_pkg::RAW8;
            cfg.start_adr <= '0;
            cfg.line_ofs  <= '0;
            cfg.width     <= '0;
            cfg.height    <= '0;
            sof_en        <= 1'b0;
            fidx          <= '0;
            irq_en        <= 1'b0;
            busy          <= 1'b0;
            done          <= 1'b0;
        end else begin
            ioa_rdy   <= acc;
            cfg.start <= 1'b0;
            if (acc) begin
                ioa_rdata <= ioa_rd ? rd_val : '0;
            end

            // frame settings only change between frames
            if (wr_en && !busy) begin
                case (reg_sel)
                    mlr_pkg::CTRL: begin
                        sof_en    <= ioa_wdata[1];
                        cfg.start <= ioa_wdata[0];
                        busy      <= ioa_wdata[0];
                    end
                    mlr_pkg::FMT:       cfg.pack_fmt  <= mlr_pkg::pack_fmt_e'(ioa_wdata[1:0]);
                    mlr_pkg::START_ADR: cfg.start_adr <= ioa_wdata[mlr_pkg::ADR_W-1:0];
                    mlr_pkg::LINE_OFS:  cfg.line_ofs  <= ioa_wdata[mlr_pkg::OFS_W-1:0];
                    mlr_pkg::WIDTH:     cfg.width     <= ioa_wdata[mlr_pkg::DIM_W-1:0];
                    mlr_pkg::HEIGHT:    cfg.height    <= ioa_wdata[mlr_pkg::DIM_W-1:0];
                    mlr_pkg::FIDX:      fidx          <= ioa_wdata[mlr_pkg::FIDX_W-1:0];
                    default: ;
                endcase
            end

            if (wr_en && reg_sel == mlr_pkg::IRQ_EN) begin
                irq_en <= ioa_wdata[0];
            end

            if (frame_done) begin
                done <= 1'b1;
                busy <= 1'b0;
            end else if (wr_en && reg_sel == mlr_pkg::STATUS && ioa_wdata[0]) begin
                done <= 1'b0;  // write one to clear
            end
        end
    end

    // no second start until the unpacker reports the frame out
    a_one_start_per_frame: assert property (
        @(posedge clk_kernel) disable iff (rst)
        cfg.start |=> (!cfg.start throughout frame_done[->1])
    );

endmodule

// ==== src/mlr_fetch.sv ====
module mlr_fetch #(
    parameter int FIFO_DEPTH_W = 2
) (
    input  logic                         clk_kernel,
    input  logic                         rst,
    mlr_cfg_if.sink                      cfg,
    output logic                         mem_cmdval,
    output logic [mlr_pkg::ADR_W-1:0]    mem_addr,
    input  logic                         mem_cmdack,
    input  logic                         mem_rspval,
    input  logic [mlr_pkg::BUS_W-1:0]    mem_rdata,
    mlr_word_if.source                   word
);

    localparam int DEPTH = 1 << FIFO_DEPTH_W;

    mlr_pkg::fetch_state_e        state;
    logic [mlr_pkg::DIM_W-1:0]    beat_cnt;
    logic [mlr_pkg::DIM_W-1:0]    line_cnt;
    logic [mlr_pkg::ADR_W-1:0]    line_base;
    logic [FIFO_DEPTH_W:0]        credit_cnt;   // issued, not yet popped by unpack
    logic                         cmd_acc;
    logic                         last_beat;
    logic                         last_row;

    // response tags, in command order
    logic [1:0]                   tag_mem [DEPTH];
    logic [FIFO_DEPTH_W-1:0]      tag_wr;
    logic [FIFO_DEPTH_W-1:0]      tag_rd;
    logic [FIFO_DEPTH_W:0]        tag_cnt;

    assign last_beat  = beat_cnt == cfg.width - 1'b1;
    assign last_row   = line_cnt == cfg.height - 1'b1;
    assign mem_cmdval = (state == mlr_pkg::RUN) && !credit_cnt[FIFO_DEPTH_W];
    assign cmd_acc    = mem_cmdval & mem_cmdack;

    assign word.valid     = mem_rspval;
    assign word.data      = mem_rdata;
    assign word.last_line = tag_mem[tag_rd][1];
    assign word.last_pix  = tag_mem[tag_rd][0];

    always_ff @(posedge clk_kernel) begin
        if (rst) begin
            state    <= mlr_pkg::IDLE;
            beat_cnt <= '0;
            line_cnt <= '0;
        end else begin
            case (state)
                mlr_pkg::IDLE: begin
                    if (cfg.start) begin
                        state    <= mlr_pkg::RUN;
                        beat_cnt <= '0;
                        line_cnt <= '0;
                    end
                end
                mlr_pkg::RUN: begin
                    if (cmd_acc) begin
                        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
                        if (last_beat) begin
                            line_cnt <= line_cnt + 1'b1;
                            if (last_row) state <= mlr_pkg::DRAIN;
                        end
                    end
                end
                default: begin
                    if (tag_cnt == '0) state <= mlr_pkg::IDLE;  // all responses in
                end
            endcase
        end
    end

    // address walk
    always_ff @(posedge clk_kernel) begin
        if (state == mlr_pkg::IDLE && cfg.start) begin
            line_base <= cfg.start_adr;
            mem_addr  <= cfg.start_adr;
        end else if (cmd_acc) begin
            if (last_beat) begin
                line_base <= line_base + mlr_pkg::ADR_W'(cfg.line_ofs);
                mem_addr  <= line_base + mlr_pkg::ADR_W'(cfg.line_ofs);
            end else begin
                mem_addr  <= mem_addr + 8;
            end
        end
    end

    always_ff @(posedge clk_kernel) begin
        if (rst) begin
            credit_cnt <= '0;
            tag_cnt    <= '0;
            tag_wr     <= '0;
            tag_rd     <= '0;
        end else begin
            case ({cmd_acc, word.pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: ;
            endcase
            case ({cmd_acc, mem_rspval})
                2'b10:   tag_cnt <= tag_cnt + 1'b1;
                2'b01:   tag_cnt <= tag_cnt - 1'b1;
                default: ;
            endcase
            if (cmd_acc) tag_wr <= tag_wr + 1'b1;
            if (mem_rspval) tag_rd <= tag_rd + 1'b1;
        end
    end

    always_ff @(posedge clk_kernel) begin
        if (cmd_acc) tag_mem[tag_wr] <= {last_row, last_beat};
    end

    a_rsp_has_cmd: assert property (
        @(posedge clk_kernel) disable iff (rst)
        mem_rspval |-> tag_cnt != '0
    );

endmodule

// ==== src/mlr_unpack.sv ====
module mlr_unpack #(
    parameter int FIFO_DEPTH_W = 2
) (
    input  logic                         clk_kernel,
    input  logic                         rst,
    mlr_cfg_if.fmt_rd                    pack_fmt,
    input  logic                         sof_en,
    mlr_word_if.sink                     word,
    input  logic                         pix_req,
    output logic                         pix_rdy,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_0,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_1,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_2,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_3,
    output logic                         pix_heff,
    output logic                         pix_veff,
    output logic                         pix_sof,
    output logic                         pix_eol,
    output logic                         frame_done
);

    localparam int DEPTH = 1 << FIFO_DEPTH_W;
    localparam int DW    = mlr_pkg::DATA_W;
    localparam int ENT_W = mlr_pkg::BUS_W + 2;

    logic [ENT_W-1:0]          q_mem [DEPTH];
    logic [FIFO_DEPTH_W-1:0]   q_wr;
    logic [FIFO_DEPTH_W-1:0]   q_rd;
    logic [FIFO_DEPTH_W:0]     q_cnt;
    logic [ENT_W-1:0]          head;
    logic                      xfer;
    logic                      sof_pend;
    logic [DW-1:0]             pix [mlr_pkg::PIX_PER_BEAT];

    assign head     = q_mem[q_rd];
    assign pix_rdy  = q_cnt != '0;
    assign xfer     = pix_req & pix_rdy;
    assign word.pop = xfer;

    assign pix_heff   = pix_rdy;
    assign pix_eol    = pix_rdy & head[mlr_pkg::BUS_W];
    assign pix_sof    = pix_rdy & sof_pend & sof_en;
    assign frame_done = xfer & head[mlr_pkg::BUS_W+1] & head[mlr_pkg::BUS_W];

    // slice the head word from bit 0 up, zero-padded
    always_comb begin
        for (int i = 0; i < mlr_pkg::PIX_PER_BEAT; i++) begin
            case (pack_fmt.pack_fmt)
                mlr_pkg::RAW10: pix[i] = DW'(head[i*10 +: 10]);
                mlr_pkg::RAW12: pix[i] = head[i*12 +: 12];
                default:        pix[i] = DW'(head[i*8 +: 8]);
            endcase
        end
    end

    assign pix_data_0 = pix[0];
    assign pix_data_1 = pix[1];
    assign pix_data_2 = pix[2];
    assign pix_data_3 = pix[3];

    always_ff @(posedge clk_kernel) begin
        if (word.valid) q_mem[q_wr] <= {word.last_line, word.last_pix, word.data};
    end

    always_ff @(posedge clk_kernel) begin
        if (rst) begin
            q_wr     <= '0;
            q_rd     <= '0;
            q_cnt    <= '0;
            pix_veff <= 1'b0;
            sof_pend <= 1'b0;
        end else begin
            if (word.valid) q_wr <= q_wr + 1'b1;
            if (xfer) q_rd <= q_rd + 1'b1;
            case ({word.valid, xfer})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: ;
            endcase

            if (pack_fmt.start) begin
                pix_veff <= 1'b1;
                sof_pend <= 1'b1;
            end else begin
                if (xfer) sof_pend <= 1'b0;
                if (frame_done) pix_veff <= 1'b0;  // drops after last beat
            end
        end
    end

    // fetch credits keep the queue from filling past its depth
    a_queue_no_overflow: assert property (
        @(posedge clk_kernel) disable iff (rst)
        word.valid |-> !q_cnt[FIFO_DEPTH_W]
    );

endmodule

// ==== src/mipi_line_read.sv ====
module mipi_line_read #(
    parameter int FIFO_DEPTH_W = 2
) (
    input  logic                         clk_kernel,
    input  logic                         rst,
    // register bus
    input  logic                         ioa_cs,
    input  logic                         ioa_wr,
    input  logic                         ioa_rd,
    input  logic [mlr_pkg::REG_A_W-1:0]  ioa_a,
    input  logic [31:0]                  ioa_wdata,
    output logic                         ioa_rdy,
    output logic [31:0]                  ioa_rdata,
    // memory read bus
    output logic                         mem_cmdval,
    output logic [mlr_pkg::ADR_W-1:0]    mem_addr,
    input  logic                         mem_cmdack,
    input  logic                         mem_rspval,
    input  logic [mlr_pkg::BUS_W-1:0]    mem_rdata,
    // pixel stream
    input  logic                         pix_req,
    output logic                         pix_rdy,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_0,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_1,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_2,
    output logic [mlr_pkg::DATA_W-1:0]   pix_data_3,
    output logic                         pix_heff,
    output logic                         pix_veff,
    output logic                         pix_sof,
    output logic                         pix_eol,
    output logic [mlr_pkg::FIDX_W-1:0]   pix_fidx,
    output logic                         interrupt
);

    logic   frame_done;
    logic   sof_en;

    mlr_cfg_if  cfg ();
    mlr_word_if word ();

    mlr_reg_bank u_reg_bank (
        .clk_kernel (clk_kernel),
        .rst        (rst),
        .ioa_cs     (ioa_cs),
        .ioa_wr     (ioa_wr),
        .ioa_rd     (ioa_rd),
        .ioa_a      (ioa_a),
        .ioa_wdata  (ioa_wdata),
        .ioa_rdy    (ioa_rdy),
        .ioa_rdata  (ioa_rdata),
        .frame_done (frame_done),
        .cfg        (cfg.source),
        .sof_en     (sof_en),
        .fidx       (pix_fidx),
        .interrupt  (interrupt)
    );

    mlr_fetch #(
        .FIFO_DEPTH_W (FIFO_DEPTH_W)
    ) u_fetch (
        .clk_kernel (clk_kernel),
        .rst        (rst),
        .cfg        (cfg.sink),
        .mem_cmdval (mem_cmdval),
        .mem_addr   (mem_addr),
        .mem_cmdack (mem_cmdack),
        .mem_rspval (mem_rspval),
        .mem_rdata  (mem_rdata),
        .word       (word.source)
    );

    mlr_unpack #(
        .FIFO_DEPTH_W (FIFO_DEPTH_W)
    ) u_unpack (
        .clk_kernel (clk_kernel),
        .rst        (rst),
        .pack_fmt   (cfg.fmt_rd),
        .sof_en     (sof_en),
        .word       (word.sink),
        .pix_req    (pix_req),
        .pix_rdy    (pix_rdy),
        .pix_data_0 (pix_data_0),
        .pix_data_1 (pix_data_1),
        .pix_data_2 (pix_data_2),
        .pix_data_3 (pix_data_3),
        .pix_heff   (pix_heff),
        .pix_veff   (pix_veff),
        .pix_sof    (pix_sof),
        .pix_eol    (pix_eol),
        .frame_done (frame_done)
    );

endmodule

// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// memory word at a byte address, every address bit feeds the hash
function automatic logic [63:0] mem_word(input logic [31:0] addr);
    logic [31:0] h1;
    logic [31:0] h2;
    h1 = addr * 32'h9e37_79b1;
    h2 = (addr ^ (addr >> 13)) * 32'h85eb_ca6b;
    h2 = h2 ^ (h2 >> 16);
    return {h1 ^ (h2 << 5), h2 ^ addr};
endfunction

// byte address of beat k in the frame, lines are width beats long
function automatic logic [31:0] beat_addr(input logic [31:0] start, input int ofs,
                                          input int width, input int k);
    int line;
    int beat;
    line = k / width;
    beat = k % width;
    return start + 32'(line * ofs + 8 * beat);
endfunction

// pixel i of a word, fields from bit 0 upward, zero padded to 12 bits
function automatic logic [11:0] exp_pix(input logic [63:0] w, input int fmt, input int i);
    logic [63:0] s;
    case (fmt)
        1:       s = (w >> (10 * i)) & 64'h3ff;   // RAW10
        2:       s = (w >> (12 * i)) & 64'hfff;   // RAW12
        default: s = (w >> (8 * i)) & 64'hff;     // RAW8 and the spare code
    endcase
    return s[11:0];
endfunction

`endif

// ==== bench/tb_mipi_line_read.sv ====
module tb_mipi_line_read;

    localparam int NF = 5;  // frames over all tests
    localparam logic [11:0] A_CTRL      = 12'h000;
    localparam logic [11:0] A_FMT       = 12'h004;
    localparam logic [11:0] A_START_ADR = 12'h008;
    localparam logic [11:0] A_LINE_OFS  = 12'h00C;
    localparam logic [11:0] A_WIDTH     = 12'h010;
    localparam logic [11:0] A_HEIGHT    = 12'h014;
    localparam logic [11:0] A_FIDX      = 12'h018;
    localparam logic [11:0] A_STATUS    = 12'h01C;
    localparam logic [11:0] A_IRQ_EN    = 12'h020;

    logic        clk_kernel;
    logic        rst;
    logic        ioa_cs;
    logic        ioa_wr;
    logic        ioa_rd;
    logic [11:0] ioa_a;
    logic [31:0] ioa_wdata;
    logic        ioa_rdy;
    logic [31:0] ioa_rdata;
    logic        mem_cmdval;
    logic [31:0] mem_addr;
    logic        mem_cmdack;
    logic        mem_rspval;
    logic [63:0] mem_rdata;
    logic        pix_req;
    logic        pix_rdy;
    logic [11:0] pix_data_0;
    logic [11:0] pix_data_1;
    logic [11:0] pix_data_2;
    logic [11:0] pix_data_3;
    logic        pix_heff;
    logic        pix_veff;
    logic        pix_sof;
    logic        pix_eol;
    logic [15:0] pix_fidx;
    logic        interrupt;

    integer      seed = 99;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          cycle_cnt = 0;
    int          limit = 100000;
    logic [11:0] reg_addr [7];
    logic [31:0] reg_mask [7];
    logic [31:0] reg_val [7];
    int          fr_fmt [NF];
    int          fr_w [NF];
    int          fr_h [NF];
    int          fr_ofs [NF];
    int          fr_adr [NF];
    int          fr_fidx [NF];
    int          fr_sof [NF];
    int          fr_irq [NF];
    int          fr_req [NF];
    // frame being streamed, read by the responder and the pixel monitor
    int          cur_fmt;
    int          cur_w = 1;
    int          cur_h;
    int          cur_ofs;
    int          cur_adr;
    int          cur_fidx;
    int          cur_sof;
    int          req_pct = 50;
    int          cmd_idx = 0;
    int          beat_idx = 0;
    int          ack_wait = 0;
    int          rsp_wait = 0;
    logic [31:0] rsp_q [$];     // accepted commands waiting for a response

    `include "tb_model.svh"

    mipi_line_read #(.FIFO_DEPTH_W(2)) uut (.*);

    always #5 clk_kernel = ~clk_kernel;

    always @(posedge clk_kernel) begin
        cycle_cnt++;
        if (cycle_cnt > limit) begin
            $display("timeout: frame not finished within %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_beat();
        logic [31:0] addr;
        logic [63:0] w;
        if (beat_idx >= cur_w * cur_h) begin
            $display("extra pixel beat %0d after the end of the frame", beat_idx);
            err_cnt++;
        end else begin
            addr = beat_addr(32'(cur_adr), cur_ofs, cur_w, beat_idx);
            w = mem_word(addr);
            check_equal("pix_data_0", 64'(pix_data_0), 64'(exp_pix(w, cur_fmt, 0)));
            check_equal("pix_data_1", 64'(pix_data_1), 64'(exp_pix(w, cur_fmt, 1)));
            check_equal("pix_data_2", 64'(pix_data_2), 64'(exp_pix(w, cur_fmt, 2)));
            check_equal("pix_data_3", 64'(pix_data_3), 64'(exp_pix(w, cur_fmt, 3)));
            check_equal("pix_eol", 64'(pix_eol), 64'(beat_idx % cur_w == cur_w - 1));
            check_equal("pix_sof", 64'(pix_sof), 64'(beat_idx == 0 && cur_sof != 0));
            check_equal("pix_heff", 64'(pix_heff), 64'd1);
            check_equal("pix_veff", 64'(pix_veff), 64'd1);
            check_equal("pix_fidx", 64'(pix_fidx), 64'(cur_fidx));
        end
        beat_idx++;
    endtask

    // memory responder and pixel sink, everything settles before the next posedge
    always @(negedge clk_kernel) begin
        if (!rst) begin
            mem_rspval = 1'b0;
            if (rsp_q.size() > 0) begin
                if (rsp_wait == 0) begin
                    mem_rspval = 1'b1;
                    mem_rdata  = mem_word(rsp_q.pop_front());
                    rsp_wait   = rand_below(4);
                end else begin
                    rsp_wait--;
                end
            end
            mem_cmdack = 1'b0;
            if (mem_cmdval) begin
                if (ack_wait == 0) begin
                    mem_cmdack = 1'b1;  // accepted at the coming posedge
                    check_equal("mem_addr", 64'(mem_addr),
                                64'(beat_addr(32'(cur_adr), cur_ofs, cur_w, cmd_idx)));
                    rsp_q.push_back(mem_addr);
                    cmd_idx++;
                    ack_wait = rand_below(4);
                end else begin
                    ack_wait--;
                end
            end
            pix_req = rand_below(100) < req_pct;
            if (pix_req && pix_rdy) check_beat();
        end
    end

    task automatic reg_write(input logic [11:0] a, input logic [31:0] d);
        @(negedge clk_kernel);
        ioa_cs    = 1'b1;
        ioa_wr    = 1'b1;
        ioa_a     = a;
        ioa_wdata = d;
        @(negedge clk_kernel);
        ioa_cs = 1'b0;
        ioa_wr = 1'b0;
        check_equal("ioa_rdy", 64'(ioa_rdy), 64'd1);
        @(negedge clk_kernel);
        check_equal("ioa_rdy", 64'(ioa_rdy), 64'd0);
    endtask

    task automatic reg_read(input logic [11:0] a, output logic [31:0] d);
        @(negedge clk_kernel);
        ioa_cs = 1'b1;
        ioa_rd = 1'b1;
        ioa_a  = a;
        @(negedge clk_kernel);
        ioa_cs = 1'b0;
        ioa_rd = 1'b0;
        check_equal("ioa_rdy", 64'(ioa_rdy), 64'd1);
        d = ioa_rdata;
        @(negedge clk_kernel);
        check_equal("ioa_rdy", 64'(ioa_rdy), 64'd0);
    endtask

    task automatic run_frame(input int f);
        logic [31:0] st;
        cur_fmt  = fr_fmt[f];
        cur_w    = fr_w[f];
        cur_h    = fr_h[f];
        cur_ofs  = fr_ofs[f];
        cur_adr  = fr_adr[f];
        cur_fidx = fr_fidx[f];
        cur_sof  = fr_sof[f];
        req_pct  = fr_req[f];
        cmd_idx  = 0;
        beat_idx = 0;
        reg_write(A_FMT, 32'(fr_fmt[f]));
        reg_write(A_START_ADR, 32'(fr_adr[f]));
        reg_write(A_LINE_OFS, 32'(fr_ofs[f]));
        reg_write(A_WIDTH, 32'(fr_w[f]));
        reg_write(A_HEIGHT, 32'(fr_h[f]));
        reg_write(A_FIDX, 32'(fr_fidx[f]));
        reg_write(A_IRQ_EN, 32'(fr_irq[f]));
        reg_write(A_CTRL, {30'b0, fr_sof[f] != 0, 1'b1});
        while (beat_idx < cur_w * cur_h) @(negedge clk_kernel);
        @(negedge clk_kernel);  // done lands one cycle after the last beat
        check_equal("interrupt", 64'(interrupt), 64'(fr_irq[f] != 0));
        reg_read(A_STATUS, st);
        check_equal("ioa_rdata", 64'(st[1:0]), 64'd1);   // done set, busy clear
        check_equal("mem_cmdval count", 64'(cmd_idx), 64'(cur_w * cur_h));
        reg_write(A_STATUS, 32'd1);
        check_equal("interrupt", 64'(interrupt), 64'd0);
        reg_read(A_STATUS, st);
        check_equal("ioa_rdata", 64'(st[0]), 64'd0);
        check_equal("pix_veff", 64'(pix_veff), 64'd0);
    endtask

    task automatic report_test(input int t, input string name, input int e0);
        if (err_cnt == e0) $display("test %0d %s: ok", t, name);
        else $display("test %0d %s: %0d errors", t, name, err_cnt - e0);
    endtask

    initial begin
        int e0;
        int total;
        logic [31:0] rd;
        clk_kernel = 1'b0;
        rst        = 1'b1;
        ioa_cs     = 1'b0;
        ioa_wr     = 1'b0;
        ioa_rd     = 1'b0;
        ioa_a      = '0;
        ioa_wdata  = '0;
        mem_cmdack = 1'b0;
        mem_rspval = 1'b0;
        mem_rdata  = '0;
        pix_req    = 1'b0;

        reg_addr = '{A_FMT, A_START_ADR, A_LINE_OFS, A_WIDTH, A_HEIGHT, A_FIDX, A_IRQ_EN};
        reg_mask = '{32'h3, 32'hffff_ffff, 32'hffff, 32'h1fff, 32'h1fff, 32'hffff, 32'h1};
        for (int i = 0; i < 7; i++) reg_val[i] = $random(seed);
        for (int f = 0; f < NF; f++) begin
            fr_w[f]    = 1 + rand_below(8);
            fr_h[f]    = 1 + rand_below(6);
            fr_ofs[f]  = rand_below(1024);
            fr_adr[f]  = 8 * rand_below(1 << 20);
            fr_fidx[f] = rand_below(65536);
            fr_sof[f]  = rand_below(2);
            fr_irq[f]  = 1;
            fr_req[f]  = 70;
        end
        fr_fmt    = '{2, 0, 1, 2, 1};
        fr_sof[0] = 1;
        fr_w[3]   = 6 + rand_below(8);  // long frame under heavy back-pressure
        fr_h[3]   = 4 + rand_below(4);
        fr_req[3] = 25;
        fr_irq[4] = 0;
        fr_req[4] = 50;
        total = 0;
        for (int f = 0; f < NF; f++) total += fr_w[f] * fr_h[f];
        limit = 4 * total * 10 + 2000;

        repeat (10) @(negedge clk_kernel);

        e0 = err_cnt;
        // outputs idle while reset is held
        check_equal("ioa_rdy", 64'(ioa_rdy), 64'd0);
        check_equal("mem_cmdval", 64'(mem_cmdval), 64'd0);
        check_equal("pix_rdy", 64'(pix_rdy), 64'd0);
        check_equal("pix_veff", 64'(pix_veff), 64'd0);
        check_equal("pix_sof", 64'(pix_sof), 64'd0);
        check_equal("pix_eol", 64'(pix_eol), 64'd0);
        check_equal("interrupt", 64'(interrupt), 64'd0);
        rst = 1'b0;
        reg_read(A_STATUS, rd);
        check_equal("ioa_rdata", 64'(rd), 64'd0);   // not busy, not done
        for (int i = 0; i < 7; i++) reg_write(reg_addr[i], reg_val[i]);
        for (int i = 0; i < 7; i++) begin
            reg_read(reg_addr[i], rd);
            check_equal("ioa_rdata", 64'(rd), 64'(reg_val[i] & reg_mask[i]));
        end
        reg_write(A_CTRL, 32'h2);   // sof enable only, no start
        reg_read(A_CTRL, rd);
        check_equal("ioa_rdata", 64'(rd), 64'h2);
        report_test(1, "register read-back", e0);

        e0 = err_cnt;
        run_frame(0);
        report_test(2, "RAW12 frame", e0);

        e0 = err_cnt;
        run_frame(1);
        run_frame(2);
        report_test(3, "RAW8 and RAW10 frames", e0);

        e0 = err_cnt;
        run_frame(3);
        report_test(4, "back-pressure frame", e0);

        e0 = err_cnt;
        run_frame(4);
        report_test(5, "done without interrupt", e0);

        $display("5 tests, %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+bench
src/mlr_pkg.sv
src/mlr_cfg_if.sv
src/mlr_word_if.sv
src/mlr_reg_bank.sv
src/mlr_fetch.sv
src/mlr_unpack.sv
src/mipi_line_read.sv
bench/tb_mipi_line_read.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, fail status on a failing run
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_mipi_line_read -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log; echo "simulation error"; exit 1; }

grep -q "Checks failed" sim.log && exit 1 || exit 0
